// ==== hw/riscv_pkg.sv ====
// RV32I core package with shared word types, ALU op codes, opcodes and the NOP word
package riscv_pkg;

    // Data, instruction and byte-address word
    typedef logic [31:0] word_t;

    // Register number x0..x31
    typedef logic [4:0] reg_addr_t;

    // ALU operation select
    typedef logic [2:0] alu_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////////////////////////////////////////

    // ADD must stay zero, a bubble carries all-zero controls
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLT = 3'd5;

    ////////////////////////////////////////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////////////////////////////////////////

    // Register-register ALU group
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    // Register-immediate ALU group
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // ADDI x0,x0,0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== hw/pipe_if.sv ====
// Pipeline buses between decode and execute, and between execute and memory

// ID/EX bus, operands and controls for one instruction
interface id_ex_if;
    riscv_pkg::reg_addr_t rs1;
    riscv_pkg::reg_addr_t rs2;
    riscv_pkg::word_t     rs1_data;
    riscv_pkg::word_t     rs2_data;
    riscv_pkg::reg_addr_t rd;
    riscv_pkg::word_t     imm;
    riscv_pkg::alu_op_t   alu_op;
    logic                 use_imm;
    logic                 mem_read;
    logic                 mem_write;
    logic                 reg_write;

    // Decode also reads rd and mem_read back for the load-use check
    modport producer (output rs1, rs2, rs1_data, rs2_data, rd, imm, alu_op,
                      use_imm, mem_read, mem_write, reg_write);

    modport consumer (input rs1, rs2, rs1_data, rs2_data, rd, imm, alu_op,
                      use_imm, mem_read, mem_write, reg_write);
endinterface

// EX/MEM bus, ALU result plus memory and writeback controls
interface ex_mem_if;
    riscv_pkg::word_t     alu_result;
    riscv_pkg::word_t     store_data;
    riscv_pkg::reg_addr_t rd;
    logic                 mem_read;
    logic                 mem_write;
    logic                 reg_write;

    // Execute reads its own fields back for forwarding
    modport producer (output alu_result, store_data, rd, mem_read, mem_write, reg_write);

    modport consumer (input alu_result, store_data, rd, mem_read, mem_write, reg_write);
endinterface

// ==== hw/fetch_stage.sv ====
// Fetch stage with instruction memory, program counter, run flag and IF/ID register
module fetch_stage #(
    parameter int IMEM_WORDS = 64
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             start,
    input  riscv_pkg::word_t prog_address,
    input  riscv_pkg::word_t prog_addr,
    input  riscv_pkg::word_t prog_data,
    input  logic             prog_write,
    input  logic             stall,
    output riscv_pkg::word_t instruction
);

    localparam int IDX_W = $clog2(IMEM_WORDS);

    riscv_pkg::word_t imem [IMEM_WORDS];
    riscv_pkg::word_t pc;
    logic             running;
    logic [IDX_W-1:0] pc_index;
    logic             at_last;

    // PC is a byte address, memory is word indexed
    assign pc_index = pc[IDX_W+1:2];
    assign at_last  = (pc_index == IDX_W'(IMEM_WORDS - 1));

    // Program load only while idle
    always_ff @(posedge clock) begin
        if (prog_write && !running) begin
            imem[prog_addr[IDX_W-1:0]] <= prog_data;
        end
    end

    // Run flag and PC
    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
            pc      <= '0;
        end else if (!running) begin
            if (start) begin
                running <= 1'b1;
                pc      <= prog_address;
            end
        end else if (!stall && !at_last) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID register, holds under stall
    always_ff @(posedge clock) begin
        if (reset || !running) begin
            instruction <= riscv_pkg::NOP_INSTR;
        end else if (!stall) begin
            instruction <= imem[pc_index];
        end
    end

endmodule

// ==== hw/decode_stage.sv ====
// Decode stage with register file, control decode, immediates, load-use stall and ID/EX
module decode_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  riscv_pkg::word_t     instruction,
    input  logic                 wb_write,
    input  riscv_pkg::reg_addr_t wb_reg,
    input  riscv_pkg::word_t     wb_data,
    output logic                 stall,
    id_ex_if.producer            id_ex
);

    riscv_pkg::word_t     regs [32];

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    riscv_pkg::reg_addr_t rs1_field;
    riscv_pkg::reg_addr_t rs2_field;
    riscv_pkg::reg_addr_t rd_field;

    riscv_pkg::word_t     imm_i;
    riscv_pkg::word_t     imm_s;
    riscv_pkg::word_t     imm_u;

    // Decoded controls
    riscv_pkg::reg_addr_t rs1;
    riscv_pkg::reg_addr_t rs2;
    riscv_pkg::reg_addr_t rd;
    riscv_pkg::word_t     imm;
    riscv_pkg::alu_op_t   alu_op;
    logic                 use_imm;
    logic                 mem_read;
    logic                 mem_write;
    logic                 reg_write;

    riscv_pkg::word_t     rs1_data;
    riscv_pkg::word_t     rs2_data;

    assign opcode    = instruction[6:0];
    assign funct3    = instruction[14:12];
    assign rs1_field = instruction[19:15];
    assign rs2_field = instruction[24:20];
    assign rd_field  = instruction[11:7];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_u = {instruction[31:12], 12'd0};

    ////////////////////////////////////////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////////////////////////////////////////

    // Unused source fields become x0 so they never forward or stall
    always_comb begin
        rs1       = '0;
        rs2       = '0;
        rd        = '0;
        imm       = imm_i;
        alu_op    = riscv_pkg::ALU_ADD;
        use_imm   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        case (opcode)
            riscv_pkg::OPC_OP: begin
                rs1       = rs1_field;
                rs2       = rs2_field;
                rd        = rd_field;
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = instruction[30] ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
                    3'b010:  alu_op = riscv_pkg::ALU_SLT;
                    3'b100:  alu_op = riscv_pkg::ALU_XOR;
                    3'b110:  alu_op = riscv_pkg::ALU_OR;
                    3'b111:  alu_op = riscv_pkg::ALU_AND;
                    default: reg_write = 1'b0;
                endcase
            end
            riscv_pkg::OPC_OP_IMM: begin
                rs1       = rs1_field;
                rd        = rd_field;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = riscv_pkg::ALU_ADD;
                    3'b010:  alu_op = riscv_pkg::ALU_SLT;
                    3'b100:  alu_op = riscv_pkg::ALU_XOR;
                    3'b110:  alu_op = riscv_pkg::ALU_OR;
                    3'b111:  alu_op = riscv_pkg::ALU_AND;
                    default: reg_write = 1'b0;
                endcase
            end
            // x0 + upper immediate
            riscv_pkg::OPC_LUI: begin
                rd        = rd_field;
                imm       = imm_u;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            riscv_pkg::OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    rs1       = rs1_field;
                    rd        = rd_field;
                    use_imm   = 1'b1;
                    mem_read  = 1'b1;
                    reg_write = 1'b1;
                end
            end
            riscv_pkg::OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    rs1       = rs1_field;
                    rs2       = rs2_field;
                    imm       = imm_s;
                    use_imm   = 1'b1;
                    mem_write = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write && (wb_reg != 5'd0)) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // Write-first bypass from writeback
    assign rs1_data = (rs1 == 5'd0) ? '0 :
                      (wb_write && (wb_reg == rs1)) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 :
                      (wb_write && (wb_reg == rs2)) ? wb_data : regs[rs2];

    // Load in EX whose rd is needed here
    assign stall = id_ex.mem_read && (id_ex.rd != 5'd0) &&
                   ((rs1 == id_ex.rd) || (rs2 == id_ex.rd));

    // ID/EX register, bubble under stall
    always_ff @(posedge clock) begin
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm;
        if (reset || stall) begin
            id_ex.rd        <= '0;
            id_ex.alu_op    <= riscv_pkg::ALU_ADD;
            id_ex.use_imm   <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.reg_write <= 1'b0;
        end else begin
            id_ex.rd        <= rd;
            id_ex.alu_op    <= alu_op;
            id_ex.use_imm   <= use_imm;
            id_ex.mem_read  <= mem_read;
            id_ex.mem_write <= mem_write;
            id_ex.reg_write <= reg_write;
        end
    end

endmodule

// ==== hw/execute_stage.sv ====
// Execute stage with operand forwarding, ALU and EX/MEM register
module execute_stage (
    input  logic                 clock,
    input  logic                 reset,
    id_ex_if.consumer            id_ex,
    input  logic                 wb_write,
    input  riscv_pkg::reg_addr_t wb_reg,
    input  riscv_pkg::word_t     wb_data,
    ex_mem_if.producer           ex_mem
);

    riscv_pkg::word_t operand_a;
    riscv_pkg::word_t fwd_b;
    riscv_pkg::word_t operand_b;
    riscv_pkg::word_t alu_result;

    // Newest value first, EX/MEM then writeback then register file
    function automatic riscv_pkg::word_t forward(
        input riscv_pkg::reg_addr_t src,
        input riscv_pkg::word_t     reg_value
    );
        riscv_pkg::word_t value;
        value = reg_value;
        if (src != 5'd0) begin
            if (ex_mem.reg_write && (ex_mem.rd == src)) begin
                value = ex_mem.alu_result;
            end else if (wb_write && (wb_reg == src)) begin
                value = wb_data;
            end
        end
        return value;
    endfunction

    always_comb begin
        operand_a = forward(id_ex.rs1, id_ex.rs1_data);
        fwd_b     = forward(id_ex.rs2, id_ex.rs2_data);
    end

    assign operand_b = id_ex.use_imm ? id_ex.imm : fwd_b;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (id_ex.alu_op)
            riscv_pkg::ALU_ADD: alu_result = operand_a + operand_b;
            riscv_pkg::ALU_SUB: alu_result = operand_a - operand_b;
            riscv_pkg::ALU_AND: alu_result = operand_a & operand_b;
            riscv_pkg::ALU_OR:  alu_result = operand_a | operand_b;
            riscv_pkg::ALU_XOR: alu_result = operand_a ^ operand_b;
            // Signed compare
            riscv_pkg::ALU_SLT: alu_result = {31'd0, $signed(operand_a) < $signed(operand_b)};
            default:            alu_result = '0;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clock) begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= fwd_b;
        if (reset) begin
            ex_mem.rd        <= '0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.reg_write <= 1'b0;
        end else begin
            ex_mem.rd        <= id_ex.rd;
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
            ex_mem.reg_write <= id_ex.reg_write;
        end
    end

endmodule

// ==== hw/memory_stage.sv ====
// Memory and writeback stage with data memory, MEM/WB register and result report
module memory_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                 clock,
    input  logic                 reset,
    ex_mem_if.consumer           ex_mem,
    output logic                 wb_write,
    output riscv_pkg::reg_addr_t wb_reg,
    output riscv_pkg::word_t     wb_data,
    output logic                 result_valid,
    output riscv_pkg::reg_addr_t result_reg,
    output riscv_pkg::word_t     result_data
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    riscv_pkg::word_t dmem [DMEM_WORDS];
    logic [IDX_W-1:0] mem_index;

    // MEM/WB register
    riscv_pkg::word_t memwb_load_data;
    riscv_pkg::word_t memwb_alu_result;
    logic             memwb_mem_read;
    logic             report_reg;

    // Word index from the byte address
    assign mem_index = ex_mem.alu_result[IDX_W+1:2];

    always_ff @(posedge clock) begin
        if (ex_mem.mem_write) begin
            dmem[mem_index] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clock) begin
        memwb_load_data  <= dmem[mem_index];
        memwb_alu_result <= ex_mem.alu_result;
        if (reset) begin
            wb_write       <= 1'b0;
            wb_reg         <= '0;
            memwb_mem_read <= 1'b0;
        end else begin
            wb_write       <= ex_mem.reg_write;
            wb_reg         <= ex_mem.rd;
            memwb_mem_read <= ex_mem.mem_read;
        end
    end

    assign wb_data = memwb_mem_read ? memwb_load_data : memwb_alu_result;

    ////////////////////////////////////////////////////////////////////////////
    // Result report
    ////////////////////////////////////////////////////////////////////////////

    // s1 and s2..s9, i.e. x9 and x18-x25
    assign report_reg = (wb_reg == 5'd9) || ((wb_reg >= 5'd18) && (wb_reg <= 5'd25));

    always_ff @(posedge clock) begin
        result_reg  <= wb_reg;
        result_data <= wb_data;
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= wb_write && report_reg;
        end
    end

endmodule

// ==== hw/riscv_core.sv ====
// Five-stage RV32I core top level joining fetch, decode, execute and memory stages
module riscv_core #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  riscv_pkg::word_t     prog_address,
    input  logic                 prog_write,
    input  riscv_pkg::word_t     prog_addr,
    input  riscv_pkg::word_t     prog_data,
    output logic                 result_valid,
    output riscv_pkg::reg_addr_t result_reg,
    output riscv_pkg::word_t     result_data
);

    riscv_pkg::word_t     instruction;
    logic                 stall;

    // Writeback bus
    logic                 wb_write;
    riscv_pkg::reg_addr_t wb_reg;
    riscv_pkg::word_t     wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    fetch_stage #(
        .IMEM_WORDS (IMEM_WORDS)
    ) fetch (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .prog_address (prog_address),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .prog_write   (prog_write),
        .stall        (stall),
        .instruction  (instruction)
    );

    decode_stage decode (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .wb_write    (wb_write),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .stall       (stall),
        .id_ex       (id_ex.producer)
    );

    execute_stage execute (
        .clock    (clock),
        .reset    (reset),
        .id_ex    (id_ex.consumer),
        .wb_write (wb_write),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .ex_mem   (ex_mem.producer)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) memory (
        .clock        (clock),
        .reset        (reset),
        .ex_mem       (ex_mem.consumer),
        .wb_write     (wb_write),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .result_valid (result_valid),
        .result_reg   (result_reg),
        .result_data  (result_data)
    );

endmodule

// ==== sim/tb_riscv_core.sv ====
// Testbench for the RV32I core that loads a program, starts it and checks result reports
module tb_riscv_core;

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;

    logic                 clock;
    logic                 reset;
    logic                 start;
    riscv_pkg::word_t     prog_address;
    logic                 prog_write;
    riscv_pkg::word_t     prog_addr;
    riscv_pkg::word_t     prog_data;
    logic                 result_valid;
    riscv_pkg::reg_addr_t result_reg;
    riscv_pkg::word_t     result_data;

    // Program words and expected reports from the data file
    int                   prog_index [$];
    riscv_pkg::word_t     prog_word [$];
    riscv_pkg::reg_addr_t exp_reg [$];
    riscv_pkg::word_t     exp_data [$];

    int                   value_errors = 0;
    int                   protocol_errors = 0;
    logic                 started = 1'b0;
    logic                 loaded = 1'b0;

    riscv_core #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) DUT (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .prog_address (prog_address),
        .prog_write   (prog_write),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .result_valid (result_valid),
        .result_reg   (result_reg),
        .result_data  (result_data)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_testdata();
        integer              fd;
        integer              status;
        integer              count;
        integer              index;
        logic [7:0]          kind;
        logic [31:0]         value;
        logic [8*96-1:0]     line;
        fd = $fopen("sim/riscv_testdata.txt", "r");
        if (fd == 0) begin
            protocol_errors++;
            $display("cannot open sim/riscv_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line   = '0;
                status = $fgets(line, fd);
                count  = (status != 0) ? $sscanf(line, "%s %d %h", kind, index, value) : 0;
                // Comment and blank lines fall through here
                if (count == 3 && kind == "P") begin
                    prog_index.push_back(index);
                    prog_word.push_back(value);
                end else if (count == 3 && kind == "E") begin
                    exp_reg.push_back(riscv_pkg::reg_addr_t'(index));
                    exp_data.push_back(value);
                end
            end
            $fclose(fd);
        end
    endtask

    // Fill words have opcode zero and decode as NOPs
    // The last word comes out all zero
    function automatic riscv_pkg::word_t idle_word(input int index);
        return riscv_pkg::word_t'(index ^ (IMEM_WORDS - 1)) << 7;
    endfunction

    task automatic write_word(input int index, input riscv_pkg::word_t data);
        @(posedge clock);
        #1;
        prog_write = 1'b1;
        prog_addr  = riscv_pkg::word_t'(index);
        prog_data  = data;
    endtask

    task automatic check_result_reg(input riscv_pkg::reg_addr_t actual,
                                    input riscv_pkg::reg_addr_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error at %0t: report names x%0d, expected x%0d",
                     $time, actual, expected);
        end
    endtask

    task automatic check_result_data(input riscv_pkg::word_t actual,
                                     input riscv_pkg::word_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error at %0t: report value %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
    endtask

    // Report monitor on the falling edge
    always @(negedge clock) begin
        if (!reset) begin
            if (!started && result_valid !== 1'b0) begin
                protocol_errors++;
                $display("result_valid was not low before start at time %0t", $time);
            end else if (result_valid === 1'b1) begin
                if (exp_reg.size() == 0) begin
                    protocol_errors++;
                    $display("unexpected extra report for x%0d at time %0t", result_reg, $time);
                end else begin
                    check_result_reg(result_reg, exp_reg.pop_front());
                    check_result_data(result_data, exp_data.pop_front());
                end
            end
        end
    end

    // Watchdog allows 20 cycles per program word plus slack
    initial begin
        int timeout_cycles;
        wait (loaded);
        timeout_cycles = 20 * prog_index.size() + 50;
        repeat (timeout_cycles) @(posedge clock);
        $display("timeout after %0d cycles with %0d expected reports never seen",
                 timeout_cycles, exp_reg.size());
        print_counts();
        $display("sim failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset        = 1'b1;
        start        = 1'b0;
        prog_address = '0;
        prog_write   = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        load_testdata();
        loaded = 1'b1;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int i = 0; i < IMEM_WORDS; i++) begin
            write_word(i, idle_word(i));
        end
        for (int i = 0; i < prog_index.size(); i++) begin
            write_word(prog_index[i], prog_word[i]);
        end
        @(posedge clock);
        #1;
        prog_write   = 1'b0;
        start        = 1'b1;
        prog_address = '0;
        started      = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;

        while (exp_reg.size() != 0) begin
            @(posedge clock);
        end
        // Drain for the whole memory plus pipeline depth so extra reports show up
        repeat (IMEM_WORDS + 8) @(posedge clock);

        print_counts();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== sim/riscv_testdata.txt ====
# P <word index, decimal> <instruction, hex>
# E <register, decimal> <expected report value, hex>, in report order
P 0 00500493 # addi x9, x0, 5
E 9 00000005
P 1 FFD00913 # addi x18, x0, -3
E 18 FFFFFFFD
P 2 5A006993 # ori x19, x0, 0x5a0
E 19 000005A0
P 3 FFF04A13 # xori x20, x0, -1
E 20 FFFFFFFF
P 4 7FF07A93 # andi x21, x0, 0x7ff
E 21 00000000
P 5 FFE92B13 # slti x22, x18, -2
E 22 00000001
P 6 12345BB7 # lui x23, 0x12345
E 23 12345000
P 7 FFFFFC37 # lui x24, 0xfffff
E 24 FFFFF000
P 8 01248CB3 # add x25, x9, x18
E 25 00000002
P 9 409904B3 # sub x9, x18, x9
E 9 FFFFFFF8
P 10 018BF9B3 # and x19, x23, x24
E 19 12345000
P 11 016BEA33 # or x20, x23, x22
E 20 12345001
P 12 017C4AB3 # xor x21, x24, x23
E 21 EDCBA000
P 13 0194AB33 # slt x22, x9, x25
E 22 00000001
P 14 009CABB3 # slt x23, x25, x9
E 23 00000000
P 15 06400913 # addi x18, x0, 100
E 18 00000064
P 16 00190993 # addi x19, x18, 1
E 19 00000065
P 17 01390A33 # add x20, x18, x19
E 20 000000C9
P 18 01490AB3 # add x21, x18, x20
E 21 0000012D
P 19 413A8B33 # sub x22, x21, x19
E 22 000000C8
P 20 12300513 # addi x10, x0, 0x123
P 21 04D50013 # addi x0, x10, 77
P 22 00A00C33 # add x24, x0, x10
E 24 00000123
P 23 00704C93 # xori x25, x0, 7
E 25 00000007
P 24 04000293 # addi x5, x0, 64
P 25 0182A423 # sw x24, 8(x5)
P 26 0082A483 # lw x9, 8(x5)
E 9 00000123
P 27 00148913 # addi x18, x9, 1
E 18 00000124
P 28 0082A303 # lw x6, 8(x5)
P 29 006309B3 # add x19, x6, x6
E 19 00000246
P 30 FF32AE23 # sw x19, -4(x5)
P 31 FFC2AA03 # lw x20, -4(x5)
E 20 00000246
P 32 009A4AB3 # xor x21, x20, x9
E 21 00000365
P 33 00249493 # slli x9, x9, 2 (unsupported, retires as nop)
P 34 00048C93 # addi x25, x9, 0
E 25 00000123

// ==== flist.f ====
hw/riscv_pkg.sv
hw/pipe_if.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/riscv_core.sv
sim/tb_riscv_core.sv

// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - files:
      - hw/riscv_pkg.sv
      - hw/pipe_if.sv
      - hw/fetch_stage.sv
      - hw/decode_stage.sv
      - hw/execute_stage.sv
      - hw/memory_stage.sv
      - hw/riscv_core.sv
  - target: simulation
    files:
      - sim/tb_riscv_core.sv
